// File: rv_core.f
common/rv_pkg.sv
decode/main_decoder.sv
decode/alu_decoder.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/branch_unit.sv
hdl/rv_core.sv
test/tb_clock.sv
test/rv_core_assertions.sv
test/rv_core_tb.sv

// File: test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    logic            clk;
    logic            arst_n;
    logic [31:0]     instr_addr;
    logic [31:0]     instr_data;
    rv_pkg::wb_req_t wb_req;
    rv_pkg::wb_rsp_t wb_rsp;

    logic [31:0] rom       [0:63];
    logic [31:0] mem_model [0:63];
    logic [31:0] iss_mem   [0:63];
    logic [31:0] iss_regs  [0:31];
    logic [31:0] iss_pc;
    logic [31:0] rng;
    logic [1:0]  wait_cnt;

    logic [31:0] cur_addr;
    logic [31:0] exp_next;
    logic [31:0] exp_adr;
    logic [31:0] exp_dat;
    logic        exp_mem;
    logic        exp_store;
    logic        started = 1'b0;
    logic        at_end = 1'b0;

    int value_errors = 0;
    int other_errors = 0;
    int bus_stores = 0;
    int model_stores = 0;

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_core dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

    assign instr_data = rom[instr_addr[7:2]];   // Combinational fetch

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h3c00_0000 ^ (idx * 32'h0104_0421);
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] op, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(input logic [4:0] rs2, input logic [4:0] rs1,
            input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'd2, off[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] utype(input logic [6:0] op, input logic [4:0] rd,
            input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // RV32I integer operation selected by funct3, alt is instruction bit 30
    function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes the instruction at iss_pc on the testbench state
    function automatic logic [31:0] iss_step(output logic is_mem, output logic is_store,
            output logic [31:0] st_adr, output logic [31:0] st_dat);
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] ea;
        logic [31:0] res;
        logic [31:0] next;
        logic        wr;
        logic        cond;
        instr = rom[iss_pc[7:2]];
        a = iss_regs[instr[19:15]];
        b = iss_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'h000};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        next = iss_pc + 32'd4;
        res = '0;
        wr = 1'b0;
        cond = 1'b0;
        is_mem = 1'b0;
        is_store = 1'b0;
        st_adr = '0;
        st_dat = '0;
        case (instr[6:0])
            7'h33: begin
                res = arith_result(instr[14:12], instr[30], a, b);
                wr = 1'b1;
            end
            7'h13: begin
                res = arith_result(instr[14:12], instr[30] && instr[14:12] == 3'd5, a, imm_i);
                wr = 1'b1;
            end
            7'h03: begin
                ea = a + imm_i;
                res = iss_mem[ea[7:2]];
                is_mem = 1'b1;
                wr = 1'b1;
            end
            7'h23: begin
                st_adr = a + imm_s;
                st_dat = b;
                iss_mem[st_adr[7:2]] = b;
                is_mem = 1'b1;
                is_store = 1'b1;
            end
            7'h63: begin
                case (instr[14:12])
                    3'd0: cond = (a == b);
                    3'd1: cond = (a != b);
                    3'd4: cond = ($signed(a) < $signed(b));
                    3'd5: cond = ($signed(a) >= $signed(b));
                    3'd6: cond = (a < b);
                    3'd7: cond = (a >= b);
                    default: cond = 1'b0;
                endcase
                if (cond)
                    next = iss_pc + imm_b;
            end
            7'h6f: begin
                res = iss_pc + 32'd4;
                wr = 1'b1;
                next = iss_pc + imm_j;
            end
            7'h67: begin
                res = iss_pc + 32'd4;
                wr = 1'b1;
                next = (a + imm_i) & ~32'h1;
            end
            7'h37: begin
                res = imm_u;
                wr = 1'b1;
            end
            7'h17: begin
                res = iss_pc + imm_u;
                wr = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && instr[11:7] != 5'd0)
            iss_regs[instr[11:7]] = res;
        return next;
    endfunction

    initial begin
        wb_rsp = '0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
            mem_model[i] = fill_word(i);
            iss_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            iss_regs[i] = '0;
        end
        rom[0]  = utype(7'h37, 1, 20'h80000);           // lui
        rom[1]  = itype(7'h13, 3'd0, 2, 0, 12'hff9);    // -7
        rom[2]  = itype(7'h13, 3'd0, 3, 0, 12'h035);
        rom[3]  = rtype(7'h00, 3'd0, 4, 2, 3);          // add
        rom[4]  = rtype(7'h20, 3'd0, 5, 3, 2);          // sub
        rom[5]  = rtype(7'h20, 3'd5, 6, 1, 3);          // sra
        rom[6]  = itype(7'h13, 3'd5, 7, 1, 12'h003);    // srli
        rom[7]  = rtype(7'h00, 3'd2, 8, 2, 3);          // slt
        rom[8]  = itype(7'h13, 3'd3, 9, 2, 12'h003);    // sltiu
        rom[9]  = rtype(7'h00, 3'd4, 10, 2, 3);         // xor
        rom[10] = itype(7'h13, 3'd1, 11, 3, 12'h007);   // slli
        rom[11] = stype(4, 0, 12'h040);
        rom[12] = stype(5, 0, 12'h044);
        rom[13] = stype(6, 0, 12'h048);
        rom[14] = stype(7, 0, 12'h04c);
        rom[15] = stype(8, 0, 12'h050);
        rom[16] = stype(9, 0, 12'h054);
        rom[17] = stype(10, 0, 12'h058);
        rom[18] = stype(11, 0, 12'h05c);
        rom[19] = itype(7'h03, 3'd2, 12, 0, 12'h008);   // lw fill word
        rom[20] = rtype(7'h00, 3'd7, 13, 12, 2);        // and
        rom[21] = stype(13, 0, 12'h060);
        rom[22] = itype(7'h13, 3'd0, 0, 3, 12'h005);    // Write to x0
        rom[23] = utype(7'h17, 14, 20'h12345);          // auipc
        rom[24] = stype(14, 0, 12'h064);
        rom[25] = stype(0, 0, 12'h068);
        rom[26] = itype(7'h03, 3'd2, 15, 0, 12'h04c);   // lw of a stored word
        rom[27] = stype(15, 0, 12'h06c);
        rom[28] = btype(3'd0, 2, 3, 13'd8);             // beq not taken
        rom[29] = btype(3'd0, 3, 3, 13'd8);
        rom[30] = itype(7'h13, 3'd0, 16, 16, 12'h001);  // Skipped marker
        rom[31] = btype(3'd1, 3, 3, 13'd8);             // bne not taken
        rom[32] = btype(3'd1, 2, 3, 13'd8);
        rom[33] = itype(7'h13, 3'd0, 16, 16, 12'h001);
        rom[34] = btype(3'd4, 3, 2, 13'd8);             // blt not taken
        rom[35] = btype(3'd4, 2, 3, 13'd8);
        rom[36] = itype(7'h13, 3'd0, 16, 16, 12'h001);
        rom[37] = btype(3'd5, 2, 3, 13'd8);             // bge not taken
        rom[38] = btype(3'd5, 3, 2, 13'd8);
        rom[39] = itype(7'h13, 3'd0, 16, 16, 12'h001);
        rom[40] = btype(3'd6, 2, 3, 13'd8);             // bltu not taken
        rom[41] = btype(3'd6, 3, 2, 13'd8);
        rom[42] = itype(7'h13, 3'd0, 16, 16, 12'h001);
        rom[43] = btype(3'd7, 3, 2, 13'd8);             // bgeu not taken
        rom[44] = btype(3'd7, 2, 3, 13'd8);
        rom[45] = itype(7'h13, 3'd0, 16, 16, 12'h001);
        rom[46] = jtype(17, 21'd8);                     // jal
        rom[47] = itype(7'h13, 3'd0, 16, 16, 12'h001);
        rom[48] = itype(7'h13, 3'd0, 18, 0, 12'h0c8);
        rom[49] = itype(7'h67, 3'd0, 19, 18, 12'h005);  // jalr to odd sum
        rom[50] = itype(7'h13, 3'd0, 16, 16, 12'h001);
        rom[51] = stype(17, 0, 12'h070);
        rom[52] = stype(19, 0, 12'h074);
        rom[53] = stype(16, 0, 12'h078);                // Zero if no marker ran
        rom[54] = jtype(0, 21'd0);                      // Self-jump
    end

    // Wishbone slave with 0 to 3 wait cycles
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rsp   <= '0;
            wait_cnt <= '0;
            rng      <= 32'h512cb607;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_cnt == rng[1:0]) begin
                wb_rsp.ack <= 1'b1;
                wait_cnt   <= '0;
                rng        <= xorshift32(rng);
                if (wb_req.we)
                    mem_model[wb_req.adr[7:2]] <= wb_req.dat;
                else
                    wb_rsp.dat <= mem_model[wb_req.adr[7:2]];
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

    task automatic advance_model();
        exp_next = iss_step(exp_mem, exp_store, exp_adr, exp_dat);
        if (exp_store)
            model_stores++;
        if (exp_next == iss_pc)
            at_end = 1'b1;
    endtask

    // Comparison against the reference model
    always @(posedge clk) begin
        if (arst_n) begin
            if (!started) begin
                started = 1'b1;
                if (instr_addr !== 32'h0) begin
                    value_errors++;
                    $display("error: instr_addr is 0x%08h, expected 0x%08h", instr_addr, 32'h0);
                end
                cur_addr = 32'h0;
                iss_pc = 32'h0;
                advance_model();
            end else if (instr_addr !== cur_addr) begin
                if (at_end) begin
                    other_errors++;
                    $display("pc left the final self-jump");
                end
                if (instr_addr !== exp_next) begin
                    value_errors++;
                    $display("error: instr_addr is 0x%08h, expected 0x%08h", instr_addr, exp_next);
                end
                cur_addr = instr_addr;
                iss_pc = exp_next;
                advance_model();
            end
            if ((wb_req.cyc || wb_req.stb) && !exp_mem) begin
                other_errors++;
                $display("bus access at pc 0x%08h, which holds no load or store", cur_addr);
            end
            if (wb_req.stb && wb_req.sel !== 4'hf) begin
                value_errors++;
                $display("error: wb_req.sel is 0x%01h, expected 0x%01h", wb_req.sel, 4'hf);
            end
            if (wb_req.stb && wb_rsp.ack && wb_req.we) begin
                bus_stores++;
                if (!exp_store) begin
                    other_errors++;
                    $display("store acknowledged at pc 0x%08h, which holds no store", cur_addr);
                end else begin
                    if (wb_req.adr !== exp_adr) begin
                        value_errors++;
                        $display("error: wb_req.adr is 0x%08h, expected 0x%08h",
                                 wb_req.adr, exp_adr);
                    end
                    if (wb_req.dat !== exp_dat) begin
                        value_errors++;
                        $display("error: wb_req.dat is 0x%08h, expected 0x%08h",
                                 wb_req.dat, exp_dat);
                    end
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (!started && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!started) begin
            other_errors++;
            $display("core did not come out of reset within 20 cycles");
        end
        cycles = 0;
        while (!at_end && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!at_end) begin
            other_errors++;
            $display("program did not reach its final self-jump within 2000 cycles");
        end
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);         // Watch for stray bus traffic
        end
        if (bus_stores != model_stores) begin
            other_errors++;
            $display("%0d stores acknowledged on the bus, %0d executed by the model",
                     bus_stores, model_stores);
        end
        $display("value errors: %0d, other errors: %0d, stores: %0d",
                 value_errors, other_errors, bus_stores);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
    input logic            clk,
    input logic            arst_n,
    input rv_pkg::wb_req_t wb_req,
    input rv_pkg::wb_rsp_t wb_rsp
);

    stb_with_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        wb_req.stb |-> wb_req.cyc)
        else $error("stb raised without cyc");

    // Request must hold while the slave stalls
    req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_req.stb && !wb_rsp.ack) |=>
            ($stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat)))
        else $error("adr, we or dat changed while waiting for ack");

    idle_in_reset: assert property (@(posedge clk)
        !arst_n |-> !wb_req.cyc)
        else $error("cyc high during reset");

    stb_drops_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_req.stb && wb_rsp.ack) |=> !wb_req.stb)
        else $error("stb still high in the cycle after ack");

endmodule

bind rv_core rv_core_assertions assertions_i (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam time half_period = 10ns;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        arst_n = 1'b1;
        #1 arst_n = 1'b0;           // Clean falling edge for the async reset
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic [rv_pkg::xlen-1:0] instr_addr,
    input  logic [rv_pkg::xlen-1:0] instr_data,
    output rv_pkg::wb_req_t         wb_req,
    input  rv_pkg::wb_rsp_t         wb_rsp
);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] pc_target;
    logic [rv_pkg::xlen-1:0] next_pc;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] rs1_val;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] alu_y;
    logic [rv_pkg::xlen-1:0] wdata;
    rv_pkg::ctrl_t           ctrl;
    rv_pkg::alu_ctl_e        alu_ctl;
    logic                    taken;
    logic                    is_jalr;
    logic                    mem_op;
    logic                    access;
    logic                    access_done;
    logic                    advance;
    logic                    done;

    main_decoder main_decoder_i (
        .opcode (instr_data[6:0]),
        .funct3 (instr_data[14:12]),
        .ctrl   (ctrl)
    );

    alu_decoder alu_decoder_i (
        .alu_op   (ctrl.alu_op),
        .funct3   (instr_data[14:12]),
        .funct7_5 (instr_data[30]),
        .is_rtype (instr_data[6:0] == rv_pkg::op_r),
        .alu_ctl  (alu_ctl)
    );

    imm_gen imm_gen_i (
        .instr   (instr_data),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (instr_data[19:15]),
        .rs2    (instr_data[24:20]),
        .rd     (instr_data[11:7]),
        .wdata  (wdata),
        .we     (ctrl.reg_write && advance),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    assign op_a = ctrl.op1_pc  ? pc  : rs1_val;
    assign op_b = ctrl.op2_imm ? imm : rs2_val;

    alu alu_i (
        .a       (op_a),
        .b       (op_b),
        .alu_ctl (alu_ctl),
        .y       (alu_y)
    );

    branch_unit branch_unit_i (
        .br_ctl  (ctrl.br_ctl),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .taken   (taken)
    );

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;
    assign is_jalr   = (ctrl.br_ctl == rv_pkg::br_always) && !ctrl.op1_pc;

    always_comb begin
        if (is_jalr)
            next_pc = {alu_y[31:1], 1'b0};
        else if (taken)
            next_pc = pc_target;
        else
            next_pc = pc_plus4;
    end

    // Issue once, then a one-cycle gap after ack
    assign mem_op      = ctrl.mem_write || ctrl.mem_read;
    assign access      = mem_op && !done;
    assign access_done = access && wb_rsp.ack;
    assign advance     = !mem_op || access_done;

    always_comb begin
        wb_req.cyc = access;
        wb_req.stb = access;
        wb_req.we  = ctrl.mem_write;
        wb_req.adr = alu_y;
        wb_req.dat = rs2_val;
        wb_req.sel = 4'hf;      // Word accesses only
    end

    always_comb begin
        case (ctrl.wb_src)
            rv_pkg::wb_pc_plus4: wdata = pc_plus4;
            rv_pkg::wb_alu:      wdata = alu_y;
            rv_pkg::wb_imm:      wdata = imm;
            default:             wdata = wb_rsp.dat;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc   <= '0;
            done <= 1'b1;       // Holds the bus idle until reset ends
        end else begin
            done <= access_done;
            if (advance) begin
                pc <= next_pc;
            end
        end
    end

    assign instr_addr = pc;

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  rv_pkg::br_ctl_e         br_ctl,
    input  logic [rv_pkg::xlen-1:0] rs1_val,
    input  logic [rv_pkg::xlen-1:0] rs2_val,
    output logic                    taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_val == rs2_val);
    assign lt_s = ($signed(rs1_val) < $signed(rs2_val));
    assign lt_u = (rs1_val < rs2_val);

    always_comb begin
        case (br_ctl)
            rv_pkg::br_eq:     taken = eq;
            rv_pkg::br_ne:     taken = !eq;
            rv_pkg::br_always: taken = 1'b1;
            rv_pkg::br_lt:     taken = lt_s;
            rv_pkg::br_ge:     taken = !lt_s;
            rv_pkg::br_geu:    taken = !lt_u;
            rv_pkg::br_ltu:    taken = lt_u;
            default:           taken = 1'b0;   // never
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic [rv_pkg::xlen-1:0] wdata,
    input  logic                    we,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2
);

    logic [rv_pkg::xlen-1:0] regs [1:31];   // No storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_ctl_e        alu_ctl,
    output logic [rv_pkg::xlen-1:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_ctl)
            rv_pkg::alu_add:  y = a + b;
            rv_pkg::alu_sub:  y = a - b;
            rv_pkg::alu_sll:  y = a << shamt;
            rv_pkg::alu_slt:  y = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu: y = {31'b0, a < b};
            rv_pkg::alu_xor:  y = a ^ b;
            rv_pkg::alu_srl:  y = a >> shamt;
            rv_pkg::alu_sra:  y = $unsigned($signed(a) >>> shamt);
            rv_pkg::alu_or:   y = a | b;
            rv_pkg::alu_and:  y = a & b;
            default:          y = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    input  rv_pkg::imm_src_e        imm_src,
    output logic [rv_pkg::xlen-1:0] imm
);

    always_comb begin
        case (imm_src)
            rv_pkg::imm_i:
                imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::imm_s:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::imm_b:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            rv_pkg::imm_u:
                imm = {instr[31:12], 12'b0};
            rv_pkg::imm_j:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: decode/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
    input  rv_pkg::alu_op_e  alu_op,
    input  logic [2:0]       funct3,
    input  logic             funct7_5,
    input  logic             is_rtype,
    output rv_pkg::alu_ctl_e alu_ctl
);

    always_comb begin
        case (alu_op)
            rv_pkg::aluop_add:         alu_ctl = rv_pkg::alu_add;
            rv_pkg::aluop_sub_compare: alu_ctl = rv_pkg::alu_sub;
            default: begin
                case (funct3)
                    3'h0: alu_ctl = (is_rtype && funct7_5) ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'h1: alu_ctl = rv_pkg::alu_sll;
                    3'h2: alu_ctl = rv_pkg::alu_slt;
                    3'h3: alu_ctl = rv_pkg::alu_sltu;
                    3'h4: alu_ctl = rv_pkg::alu_xor;
                    3'h5: alu_ctl = funct7_5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'h6: alu_ctl = rv_pkg::alu_or;
                    default: alu_ctl = rv_pkg::alu_and;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decode/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
    input  logic [6:0]     opcode,
    input  logic [2:0]     funct3,
    output rv_pkg::ctrl_t  ctrl
);

    always_comb begin
        ctrl.alu_op    = rv_pkg::aluop_add;
        ctrl.imm_src   = rv_pkg::imm_i;
        ctrl.br_ctl    = rv_pkg::br_never;
        ctrl.mem_write = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.op1_pc    = 1'b0;
        ctrl.op2_imm   = 1'b0;
        ctrl.wb_src    = rv_pkg::wb_alu;
        ctrl.reg_write = 1'b0;

        case (opcode)
            rv_pkg::op_r: begin
                ctrl.alu_op    = rv_pkg::aluop_funct;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_load: begin
                ctrl.op2_imm   = 1'b1;    // Address is rs1 + imm
                ctrl.mem_read  = 1'b1;
                ctrl.wb_src    = rv_pkg::wb_mem;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_imm: begin
                ctrl.alu_op    = rv_pkg::aluop_funct;
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_store: begin
                ctrl.imm_src   = rv_pkg::imm_s;
                ctrl.op2_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            rv_pkg::op_branch: begin
                ctrl.alu_op  = rv_pkg::aluop_sub_compare;
                ctrl.imm_src = rv_pkg::imm_b;
                ctrl.op1_pc  = 1'b1;
                ctrl.op2_imm = 1'b1;
                case (funct3)
                    3'h0:    ctrl.br_ctl = rv_pkg::br_eq;
                    3'h1:    ctrl.br_ctl = rv_pkg::br_ne;
                    3'h4:    ctrl.br_ctl = rv_pkg::br_lt;
                    3'h5:    ctrl.br_ctl = rv_pkg::br_ge;
                    3'h6:    ctrl.br_ctl = rv_pkg::br_ltu;
                    3'h7:    ctrl.br_ctl = rv_pkg::br_geu;
                    default: ctrl.br_ctl = rv_pkg::br_never;
                endcase
            end
            rv_pkg::op_jal: begin
                ctrl.imm_src   = rv_pkg::imm_j;
                ctrl.br_ctl    = rv_pkg::br_always;
                ctrl.op1_pc    = 1'b1;
                ctrl.op2_imm   = 1'b1;
                ctrl.wb_src    = rv_pkg::wb_pc_plus4;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_jalr: begin
                ctrl.br_ctl    = rv_pkg::br_always;  // Target comes from the ALU
                ctrl.op2_imm   = 1'b1;
                ctrl.wb_src    = rv_pkg::wb_pc_plus4;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_lui: begin
                ctrl.imm_src   = rv_pkg::imm_u;
                ctrl.wb_src    = rv_pkg::wb_imm;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_auipc: begin
                ctrl.imm_src   = rv_pkg::imm_u;
                ctrl.op1_pc    = 1'b1;
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl.reg_write = 1'b0;  // Illegal opcode, no-op
        endcase
    end

endmodule

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    typedef enum logic [1:0] {
        aluop_add         = 2'b00,
        aluop_sub_compare = 2'b01,
        aluop_funct       = 2'b10
    } alu_op_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_ctl_e;

    typedef enum logic [2:0] {
        imm_i = 3'b000,
        imm_s = 3'b001,
        imm_b = 3'b010,
        imm_u = 3'b011,
        imm_j = 3'b100
    } imm_src_e;

    typedef enum logic [2:0] {
        br_eq     = 3'b000,
        br_ne     = 3'b001,
        br_never  = 3'b010,
        br_always = 3'b011,
        br_lt     = 3'b100,
        br_ge     = 3'b101,
        br_geu    = 3'b110,
        br_ltu    = 3'b111
    } br_ctl_e;

    typedef enum logic [1:0] {
        wb_pc_plus4 = 2'b00,
        wb_alu      = 2'b01,
        wb_imm      = 2'b10,
        wb_mem      = 2'b11
    } wb_src_e;

    typedef struct packed {
        alu_op_e  alu_op;
        imm_src_e imm_src;
        br_ctl_e  br_ctl;
        logic     mem_write;
        logic     mem_read;
        logic     op1_pc;      // Operand a from pc, not rs1
        logic     op2_imm;     // Operand b from immediate, not rs2
        wb_src_e  wb_src;
        logic     reg_write;
    } ctrl_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat;
        logic [3:0]      sel;
    } wb_req_t;

    typedef struct packed {
        logic [xlen-1:0] dat;
        logic            ack;
    } wb_rsp_t;

endpackage

`default_nettype wire
